/* network_cfg.svh */
`ifndef NETWORK_CFG_SVH
`define NETWORK_CFG_SVH

// Layer widths of the classifier.
`define IN_COUNT 15
`define HIDDEN_COUNT 4
`define OUT_COUNT 3

// Every activation, weight, bias and score is one signed word.
`define WORD_BITS 32

// Weights and biases are fixed point with 1.0 equal to 2**13.
`define FRAC_BITS 13

// The tables list their words in index order, so the first word is neuron 0, input 0.
// Each hidden row holds the 15 weights of one hidden neuron.
`define HIDDEN_WEIGHTS { \
	 32'sd8126,  -32'sd890, -32'sd1110, -32'sd1333,  32'sd3004, \
	 32'sd3966,  32'sd2768,  32'sd2400,  32'sd2027, -32'sd1514, \
	-32'sd5373, -32'sd5462, -32'sd1157, -32'sd5180, -32'sd2235, \
	-32'sd2410,  32'sd4512,  32'sd1876, -32'sd3320,   32'sd705, \
	-32'sd1980,  32'sd6230, -32'sd4415,  32'sd2890,  32'sd1123, \
	 -32'sd760,  32'sd3555, -32'sd2048,  32'sd4901,  32'sd1337, \
	 32'sd3071, -32'sd5120,  32'sd2264,  32'sd4789, -32'sd1543, \
	  32'sd812, -32'sd3906,  32'sd1450, -32'sd6021,  32'sd2733, \
	 32'sd4180,  -32'sd987,  32'sd5560, -32'sd1222,   32'sd690, \
	-32'sd4402, -32'sd1765,  32'sd5893,  32'sd2140, -32'sd3377, \
	-32'sd4890,  32'sd1015,  32'sd3782, -32'sd2560, -32'sd6344, \
	 32'sd1908,  32'sd2475,  -32'sd811,  32'sd3129, -32'sd5047  \
}

// Hidden biases stay below 1.0 in magnitude.
`define HIDDEN_BIASES { \
	32'sd807, -32'sd1204, 32'sd3310, -32'sd562 \
}

// Each output row holds the 4 weights of one output neuron.
`define OUTPUT_WEIGHTS { \
	 32'sd5210, -32'sd3340,  32'sd2780,  32'sd4115, \
	-32'sd2890,  32'sd6050, -32'sd1475,  32'sd3320, \
	 32'sd3900,  32'sd2215, -32'sd4680, -32'sd1960  \
}

// Classes 0 and 1 share the largest bias.
`define OUTPUT_BIASES { \
	32'sd16384, 32'sd16384, -32'sd8192 \
}

`endif

/* nnPkg.sv */
`include "network_cfg.svh"

package nnPkg;

	// Signed fixed-point word with `FRAC_BITS fraction bits.
	typedef logic signed [`WORD_BITS-1:0] wordT;

	// Index of the winning output neuron.
	typedef logic [$clog2(`OUT_COUNT)-1:0] classT;

	// Element 0 of each vector belongs to input or neuron 0.
	typedef wordT [`IN_COUNT-1:0] inVecT;
	typedef wordT [`HIDDEN_COUNT-1:0] hiddenVecT;
	typedef wordT [`OUT_COUNT-1:0] outVecT;

	// The data of a stream counts only in a cycle where valid is high.
	typedef struct packed
	{
		logic valid;
		inVecT data;
	} inStreamT;

	typedef struct packed
	{
		logic valid;
		hiddenVecT data;
	} hiddenStreamT;

	typedef struct packed
	{
		logic valid;
		outVecT data;
	} outStreamT;

	// Classifier output with the scores the decision was taken on.
	typedef struct packed
	{
		logic valid;
		classT classIdx;
		outVecT scores;
	} resultT;

endpackage

/* neuronNode.sv */
`include "network_cfg.svh"

module neuronNode #(
	parameter int inCount = `IN_COUNT,
	parameter bit reluEnable = 1'b1,
	parameter logic [inCount*`WORD_BITS-1:0] weights = '0,
	parameter nnPkg::wordT bias = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::wordT [inCount-1:0] inputs,
	output nnPkg::wordT activation
);

	nnPkg::wordT [inCount-1:0] inputsReg;
	nnPkg::wordT [inCount-1:0] products;
	nnPkg::wordT sumNext;
	nnPkg::wordT sumReg;

	// Stage 1 captures the input vector.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
		end
		else
		begin
			inputsReg <= inputs;
		end
	end

	// Weight 0 is the most significant word of the vector, as in the tables.
	// Only the low word of each product is kept, so the arithmetic wraps.
	for (genvar i = 0; i < inCount; i++)
	begin : gMul
		localparam nnPkg::wordT weight = weights[(inCount-1-i)*`WORD_BITS +: `WORD_BITS];

		assign products[i] = nnPkg::wordT'(inputsReg[i] * weight);
	end

	always_comb
	begin
		sumNext = bias;
		for (int k = 0; k < inCount; k++)
		begin
			sumNext = sumNext + products[k];
		end
	end

	// Stage 2 holds the wrapped sum.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	// Stage 3 rescales to the activation format.
	// A negative sum is cut to zero only in a ReLU layer.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (reluEnable && sumReg[`WORD_BITS-1])
		begin
			activation <= '0;
		end
		else
		begin
			activation <= sumReg >>> `FRAC_BITS;
		end
	end

endmodule

/* denseLayer.sv */
`include "network_cfg.svh"

module denseLayer #(
	parameter int inCount = `IN_COUNT,
	parameter int outCount = `HIDDEN_COUNT,
	parameter bit reluEnable = 1'b1,
	parameter logic [outCount*inCount*`WORD_BITS-1:0] weights = '0,
	parameter logic [outCount*`WORD_BITS-1:0] biases = '0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::wordT [inCount-1:0] inData,
	output logic outValid,
	output nnPkg::wordT [outCount-1:0] outData
);

	// Register stages inside every neuronNode.
	localparam int latency = 3;

	// Bits taken by the weights of one neuron.
	localparam int rowBits = inCount*`WORD_BITS;

	logic [latency-1:0] validPipe;

	// The tables start with neuron 0 at the top, so row j is counted from the MSB end.
	for (genvar j = 0; j < outCount; j++)
	begin : gNeuron
		neuronNode #(
			.inCount(inCount),
			.reluEnable(reluEnable),
			.weights(weights[(outCount-1-j)*rowBits +: rowBits]),
			.bias(biases[(outCount-1-j)*`WORD_BITS +: `WORD_BITS])
		) uNode (
			.clk(clk),
			.reset(reset),
			.inputs(inData),
			.activation(outData[j])
		);
	end

	// Valid follows the data through the same number of stages.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[latency-2:0], inValid};
		end
	end

	assign outValid = validPipe[latency-1];

endmodule

/* classSelect.sv */
`include "network_cfg.svh"

module classSelect (
	input logic clk,
	input logic reset,
	input nnPkg::outStreamT scores,
	output nnPkg::resultT result
);

	nnPkg::classT bestIdx;
	nnPkg::wordT bestScore;
	nnPkg::wordT candidate;

	// Scores are compared as signed words.
	// A later score has to be strictly larger to win, so a tie keeps the lower index.
	always_comb
	begin
		bestIdx = '0;
		bestScore = scores.data[0];
		candidate = '0;
		for (int i = 1; i < `OUT_COUNT; i++)
		begin
			candidate = scores.data[i];
			if (candidate > bestScore)
			begin
				bestScore = candidate;
				bestIdx = nnPkg::classT'(i);
			end
		end
	end

	// Valid, class and scores leave together one cycle later.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result.valid <= scores.valid;
			result.classIdx <= bestIdx;
			result.scores <= scores.data;
		end
	end

endmodule

/* nnClassifier.sv */
`include "network_cfg.svh"

module nnClassifier (
	input logic clk,
	input logic reset,
	input nnPkg::inStreamT sample,
	output nnPkg::resultT result
);

	nnPkg::hiddenStreamT hiddenStream;
	nnPkg::outStreamT outStream;

	// Hidden layer with ReLU, 3 cycles.
	denseLayer #(
		.inCount(`IN_COUNT),
		.outCount(`HIDDEN_COUNT),
		.reluEnable(1'b1),
		.weights(`HIDDEN_WEIGHTS),
		.biases(`HIDDEN_BIASES)
	) uHidden (
		.clk(clk),
		.reset(reset),
		.inValid(sample.valid),
		.inData(sample.data),
		.outValid(hiddenStream.valid),
		.outData(hiddenStream.data)
	);

	// Output layer passes negative scores through unchanged.
	denseLayer #(
		.inCount(`HIDDEN_COUNT),
		.outCount(`OUT_COUNT),
		.reluEnable(1'b0),
		.weights(`OUTPUT_WEIGHTS),
		.biases(`OUTPUT_BIASES)
	) uOutput (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenStream.valid),
		.inData(hiddenStream.data),
		.outValid(outStream.valid),
		.outData(outStream.data)
	);

	// One more cycle for the argmax, 7 in total.
	classSelect uSelect (
		.clk(clk),
		.reset(reset),
		.scores(outStream),
		.result(result)
	);

endmodule

/* tbClock.sv */
module tbClock #(
	parameter int period = 10,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(period/2) clk = ~clk;
		end
	end

	// Reset drops just after a rising edge, like every other input.
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

/* tbNnClassifier.sv */
`include "network_cfg.svh"

module tbNnClassifier;

	localparam int clockPeriod = 10;
	localparam int latency = 7;
	localparam int burstCount = 200;
	localparam int gapSamples = 100;
	localparam int maxGap = 3;
	localparam int drainLimit = latency + 3;
	localparam int sampleTotal = 1 + 2*`HIDDEN_COUNT + burstCount + gapSamples + 1;
	localparam int watchdogCycles = sampleTotal*(maxGap + 1) + 200;

	localparam logic [`HIDDEN_COUNT*`IN_COUNT*`WORD_BITS-1:0] hiddenWeights = `HIDDEN_WEIGHTS;
	localparam logic [`HIDDEN_COUNT*`WORD_BITS-1:0] hiddenBiases = `HIDDEN_BIASES;
	localparam logic [`OUT_COUNT*`HIDDEN_COUNT*`WORD_BITS-1:0] outputWeights = `OUTPUT_WEIGHTS;
	localparam logic [`OUT_COUNT*`WORD_BITS-1:0] outputBiases = `OUTPUT_BIASES;

	logic clk;
	logic reset;
	nnPkg::inStreamT sample;
	nnPkg::resultT result;

	nnPkg::resultT expectQ[$];
	int issueQ[$];
	nnPkg::resultT expected;
	nnPkg::resultT lastResult;
	nnPkg::wordT score;
	logic [31:0] lfsrState = 32'h529c;
	int cycleCount = 0;
	int resultCount = 0;
	int reluCount = 0;
	int negativeCount = 0;

	tbClock #(
		.period(clockPeriod),
		.resetCycles(4)
	) uClock (
		.clk(clk),
		.reset(reset)
	);

	nnClassifier uut (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.result(result)
	);

	task automatic abortRun(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// Galois LFSR with the taps of x^32 + x^22 + x^2 + x + 1.
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
		begin
			lfsrState = lfsrState ^ 32'h80200003;
		end
		return outBit;
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int n = 0; n < count; n++)
		begin
			value = {value[30:0], lfsrBit()};
		end
		return value;
	endfunction

	// Table word 0 sits at the most significant end of each concatenation.
	function automatic nnPkg::wordT hiddenWeight(input int j, input int i);
		int word;
		word = j*`IN_COUNT + i;
		return hiddenWeights[(`HIDDEN_COUNT*`IN_COUNT-1-word)*`WORD_BITS +: `WORD_BITS];
	endfunction

	function automatic nnPkg::wordT hiddenBias(input int j);
		return hiddenBiases[(`HIDDEN_COUNT-1-j)*`WORD_BITS +: `WORD_BITS];
	endfunction

	function automatic nnPkg::wordT outputWeight(input int k, input int j);
		int word;
		word = k*`HIDDEN_COUNT + j;
		return outputWeights[(`OUT_COUNT*`HIDDEN_COUNT-1-word)*`WORD_BITS +: `WORD_BITS];
	endfunction

	function automatic nnPkg::wordT outputBias(input int k);
		return outputBiases[(`OUT_COUNT-1-k)*`WORD_BITS +: `WORD_BITS];
	endfunction

	// The reference model wraps every sum to 32 bits and applies ReLU to the hidden layer.
	function automatic nnPkg::resultT computeExpected(input nnPkg::inVecT x);
		nnPkg::resultT r;
		nnPkg::wordT hidden [`HIDDEN_COUNT];
		nnPkg::wordT scores [`OUT_COUNT];
		nnPkg::wordT xi;
		nnPkg::wordT sum;
		int best;
		r = '0;
		for (int j = 0; j < `HIDDEN_COUNT; j++)
		begin
			sum = hiddenBias(j);
			for (int i = 0; i < `IN_COUNT; i++)
			begin
				xi = x[i];
				sum = sum + xi*hiddenWeight(j, i);
			end
			if (sum < 0)
			begin
				hidden[j] = '0;
				reluCount++;
			end
			else
			begin
				hidden[j] = sum >>> `FRAC_BITS;
			end
		end
		best = 0;
		for (int k = 0; k < `OUT_COUNT; k++)
		begin
			sum = outputBias(k);
			for (int j = 0; j < `HIDDEN_COUNT; j++)
			begin
				sum = sum + hidden[j]*outputWeight(k, j);
			end
			scores[k] = sum >>> `FRAC_BITS;
			r.scores[k] = scores[k];
			// A later score must be strictly greater, so ties stay with the lower class.
			if (scores[k] > scores[best])
			begin
				best = k;
			end
		end
		r.valid = 1'b1;
		r.classIdx = nnPkg::classT'(best);
		return r;
	endfunction

	// Activations stay in the signed 16-bit range.
	function automatic nnPkg::inVecT randomSample();
		nnPkg::inVecT x;
		logic [31:0] bits;
		for (int i = 0; i < `IN_COUNT; i++)
		begin
			bits = randomBits(16);
			x[i] = {{16{bits[15]}}, bits[15:0]};
		end
		return x;
	endfunction

	// Each input opposes (or follows) the sign of its weight, so neuron j is driven hard.
	function automatic nnPkg::inVecT reluSample(input int j, input bit positive);
		nnPkg::inVecT x;
		for (int i = 0; i < `IN_COUNT; i++)
		begin
			if ((hiddenWeight(j, i) < 0) == positive)
			begin
				x[i] = -32'sd16384;
			end
			else
			begin
				x[i] = 32'sd16384;
			end
		end
		return x;
	endfunction

	task automatic driveSample(input nnPkg::inVecT x);
		sample.valid = 1'b1;
		sample.data = x;
		expectQ.push_back(computeExpected(x));
		issueQ.push_back(cycleCount);
		@(posedge clk);
		#1;
	endtask

	task automatic idleCycles(input int count);
		sample.valid = 1'b0;
		sample.data = '0;
		repeat (count)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic waitForResults();
		int waited;
		waited = 0;
		sample.valid = 1'b0;
		sample.data = '0;
		while (expectQ.size() != 0 && waited < drainLimit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (expectQ.size() != 0)
		begin
			abortRun("Some results never came back after the pipeline drain time.");
		end
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	// Outputs change on the rising edge and are checked on the falling edge.
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (result.valid)
			begin
				assert (expectQ.size() > 0)
					else abortRun($sformatf(
						"error at time %0t: result.valid with no sample in flight",
						$time));
				expected = expectQ[0];
				assert (cycleCount == issueQ[0] + latency)
					else abortRun($sformatf(
						"error at time %0t: result %0d after %0d cycles, expected %0d",
						$time, resultCount, cycleCount - issueQ[0], latency));
				assert (result.scores == expected.scores)
					else abortRun($sformatf(
						"error at time %0t: result %0d scores %h, expected %h",
						$time, resultCount, result.scores, expected.scores));
				assert (result.classIdx == expected.classIdx)
					else abortRun($sformatf(
						"error at time %0t: result %0d class %0d, expected %0d",
						$time, resultCount, result.classIdx, expected.classIdx));
				for (int k = 0; k < `OUT_COUNT; k++)
				begin
					score = expected.scores[k];
					if (score < 0)
					begin
						negativeCount++;
					end
				end
				lastResult = result;
				expectQ.pop_front();
				issueQ.pop_front();
				resultCount++;
			end
			else
			begin
				assert (expectQ.size() == 0 || cycleCount != issueQ[0] + latency)
					else abortRun($sformatf(
						"The result of sample %0d did not arrive %0d cycles late.",
						resultCount, latency));
			end
		end
	end

	initial
	begin
		#(watchdogCycles*clockPeriod);
		abortRun("The simulation ran out of time before all samples were processed.");
	end

	initial
	begin
		sample = '0;
		@(negedge reset);
		assert (result == '0)
			else abortRun($sformatf("error at time %0t: result not cleared by reset", $time));
		idleCycles(20);

		driveSample(randomSample());
		waitForResults();

		for (int j = 0; j < `HIDDEN_COUNT; j++)
		begin
			driveSample(reluSample(j, 1'b0));
			driveSample(reluSample(j, 1'b1));
		end
		waitForResults();

		repeat (burstCount)
		begin
			driveSample(randomSample());
		end
		waitForResults();

		repeat (gapSamples)
		begin
			idleCycles(int'(randomBits(2)));
			driveSample(randomSample());
		end
		waitForResults();

		// Every hidden neuron settles to zero, so classes 0 and 1 tie on their equal bias.
		driveSample('0);
		waitForResults();
		assert (lastResult.scores[0] == lastResult.scores[1] && lastResult.classIdx == '0)
			else abortRun($sformatf("error at time %0t: zero sample tie gave class %0d",
				$time, lastResult.classIdx));

		// A stray result after the last sample still has to show up here.
		idleCycles(latency + 1);

		if (reluCount == 0 || negativeCount == 0)
		begin
			abortRun("The stimulus never produced a clamped hidden sum or a negative score.");
		end
		else
		begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

/* build.f */
+incdir+.
nnPkg.sv
neuronNode.sv
denseLayer.sv
classSelect.sv
nnClassifier.sv
tbClock.sv
tbNnClassifier.sv

/* run.sh */
#!/bin/sh
# Builds and runs the classifier testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f build.f \
	--top-module tbNnClassifier \
	-o simNnClassifier

# The pipe keeps a fatal exit from stopping the script before the log is searched.
./obj_dir/simNnClassifier | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported a failure, see sim.log."
	exit 1
fi

echo "Simulation finished without failures."
exit 0
